//--- list.f
logic/noc_pkg.sv
logic/flit_if.sv
logic/port_control_if.sv
logic/vc_input_fifo.sv
logic/route_selector.sv
logic/output_arbiter.sv
logic/vc_merger.sv
logic/router_input_path.sv
test/clock_gen.sv
test/tb_router_input_path.sv

//--- logic/flit_if.sv
`timescale 1ns/1ns

interface flit_if;

  logic               valid;
  logic               ready;
  noc_pkg::flit_word_u word;
  logic               head;
  logic               tail;

  modport initiator (
    output valid,
    output word,
    output head,
    output tail,
    input  ready
  );

  modport target (
    input  valid,
    input  word,
    input  head,
    input  tail,
    output ready
  );

endinterface

//--- logic/noc_pkg.sv
package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mesh and link sizes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int size_x      = 4;
  localparam int size_y      = 4;
  localparam int coord_width = $clog2((size_x > size_y) ? size_x : size_y);
  localparam int channels    = 2;
  localparam int vc_width    = (channels > 1) ? $clog2(channels) : 1;
  localparam int ports       = 5;
  localparam int data_width  = 32;
  localparam int fifo_depth  = 2;

  // port order of the router.
  localparam int port_x_plus  = 0;
  localparam int port_x_minus = 1;
  localparam int port_y_plus  = 2;
  localparam int port_y_minus = 3;
  localparam int port_local   = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit format.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    xy_routing = 1'b0,
    yx_routing = 1'b1
  } routing_mode_e;

  localparam int tag_width = data_width - 4 * coord_width - 1;

  typedef struct packed {
    logic [coord_width-1:0] dest_x;
    logic [coord_width-1:0] dest_y;
    routing_mode_e          routing_mode;
    logic [coord_width-1:0] src_x;
    logic [coord_width-1:0] src_y;
    logic [tag_width-1:0]   tag;
  } flit_header_t;

  // head flits carry a header, body and tail flits carry raw data.
  typedef union packed {
    flit_header_t          header;
    logic [data_width-1:0] data;
  } flit_word_u;

  // one-hot, one bit per port index.
  typedef logic [ports-1:0] route_t;

  localparam route_t route_none = '0;

endpackage

//--- logic/output_arbiter.sv
`timescale 1ns/1ns

module output_arbiter (
  input logic             clk,
  input logic             rst_n,
  port_control_if.arbiter port_control
);

  // first requester after the last winner, in circular order.
  function automatic logic [noc_pkg::channels-1:0] pick(
    input logic [noc_pkg::channels-1:0] req,
    input logic [noc_pkg::vc_width-1:0] last
  );
    logic [noc_pkg::channels-1:0] one_hot;
    int                           idx;
    one_hot = '0;
    for (int i = 1; i <= noc_pkg::channels; i++) begin
      idx = (int'(last) + i) % noc_pkg::channels;
      if (req[idx] && (one_hot == '0)) begin
        one_hot[idx] = 1'b1;
      end
    end
    return one_hot;
  endfunction

  function automatic logic [noc_pkg::vc_width-1:0] encode(
    input logic [noc_pkg::channels-1:0] one_hot
  );
    logic [noc_pkg::vc_width-1:0] index;
    index = '0;
    for (int i = 0; i < noc_pkg::channels; i++) begin
      if (one_hot[i]) begin
        index = i[noc_pkg::vc_width-1:0];
      end
    end
    return index;
  endfunction

  logic [noc_pkg::channels-1:0] grant_q;
  logic [noc_pkg::channels-1:0] grant_next;
  logic [noc_pkg::vc_width-1:0] last_q;
  logic                         idle;
  logic                         packet_done;
  logic                         head_taken;

  assign port_control.grant = grant_q;

  assign idle        = (grant_q == '0);
  assign packet_done = |(grant_q & port_control.end_of_packet);
  assign head_taken  = |(grant_q & port_control.free & port_control.start_of_packet);

  // only a waiting head can open a new packet on this port.
  assign grant_next = pick(port_control.request & port_control.start_of_packet, last_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= '0;
      last_q  <= '0;
    end else begin
      if (packet_done) begin
        grant_q <= '0;
      end else if (idle) begin
        grant_q <= grant_next;
      end
      if (head_taken) begin
        last_q <= encode(grant_q);
      end
    end
  end

endmodule

//--- logic/port_control_if.sv
`timescale 1ns/1ns

interface port_control_if;

  logic [noc_pkg::channels-1:0] request;
  logic [noc_pkg::channels-1:0] free;
  logic [noc_pkg::channels-1:0] start_of_packet;
  logic [noc_pkg::channels-1:0] end_of_packet;
  logic [noc_pkg::channels-1:0] grant;

  modport requester (
    output request,
    output free,
    output start_of_packet,
    output end_of_packet,
    input  grant
  );

  modport arbiter (
    input  request,
    input  free,
    input  start_of_packet,
    input  end_of_packet,
    output grant
  );

endinterface

//--- logic/route_selector.sv
`timescale 1ns/1ns

module route_selector #(
  parameter int                          X               = 0,
  parameter int                          Y               = 0,
  parameter logic [noc_pkg::ports-1:0]   AVAILABLE_PORTS = '1
) (
  input logic                 clk,
  input logic                 rst_n,
  flit_if.target              flit_in [noc_pkg::channels],
  flit_if.initiator           flit_out [noc_pkg::ports*noc_pkg::channels],
  port_control_if.requester   port_control [noc_pkg::ports]
);

  // dimension-order routing over the ports that exist here.
  function automatic noc_pkg::route_t select_route(input noc_pkg::flit_header_t header);
    logic [3:0]       toward;
    noc_pkg::route_t  route;
    toward[noc_pkg::port_x_plus]  = (header.dest_x > X) && AVAILABLE_PORTS[noc_pkg::port_x_plus];
    toward[noc_pkg::port_x_minus] = (header.dest_x < X) && AVAILABLE_PORTS[noc_pkg::port_x_minus];
    toward[noc_pkg::port_y_plus]  = (header.dest_y > Y) && AVAILABLE_PORTS[noc_pkg::port_y_plus];
    toward[noc_pkg::port_y_minus] = (header.dest_y < Y) && AVAILABLE_PORTS[noc_pkg::port_y_minus];
    route = noc_pkg::route_none;
    if (header.routing_mode == noc_pkg::xy_routing) begin
      if (toward[noc_pkg::port_x_plus]) route[noc_pkg::port_x_plus] = 1'b1;
      else if (toward[noc_pkg::port_x_minus]) route[noc_pkg::port_x_minus] = 1'b1;
      else if (toward[noc_pkg::port_y_plus]) route[noc_pkg::port_y_plus] = 1'b1;
      else if (toward[noc_pkg::port_y_minus]) route[noc_pkg::port_y_minus] = 1'b1;
      else route[noc_pkg::port_local] = 1'b1;
    end else begin
      if (toward[noc_pkg::port_y_plus]) route[noc_pkg::port_y_plus] = 1'b1;
      else if (toward[noc_pkg::port_y_minus]) route[noc_pkg::port_y_minus] = 1'b1;
      else if (toward[noc_pkg::port_x_plus]) route[noc_pkg::port_x_plus] = 1'b1;
      else if (toward[noc_pkg::port_x_minus]) route[noc_pkg::port_x_minus] = 1'b1;
      else route[noc_pkg::port_local] = 1'b1;
    end
    return route;
  endfunction

  for (genvar c = 0; c < noc_pkg::channels; c++) begin : g_channel
    noc_pkg::flit_header_t       header;
    noc_pkg::route_t             route_next;
    noc_pkg::route_t             route_latched;
    noc_pkg::route_t             route;
    logic                        start_of_packet;
    logic                        end_of_packet;
    logic [noc_pkg::ports-1:0]   port_ready;

    assign header          = flit_in[c].word.header;
    assign start_of_packet = flit_in[c].valid && flit_in[c].head;
    assign end_of_packet   = flit_in[c].valid && flit_in[c].ready && flit_in[c].tail;
    assign route_next      = select_route(header);

    // head flits route at once, the rest follow the latched route.
    assign route = start_of_packet ? route_next : route_latched;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        route_latched <= noc_pkg::route_none;
      end else if (end_of_packet) begin
        route_latched <= noc_pkg::route_none;
      end else if (start_of_packet) begin
        route_latched <= route_next;
      end
    end

    for (genvar p = 0; p < noc_pkg::ports; p++) begin : g_port
      if (AVAILABLE_PORTS[p]) begin : g_on
        assign flit_out[p*noc_pkg::channels+c].valid = route[p] && flit_in[c].valid;
        assign flit_out[p*noc_pkg::channels+c].word  = flit_in[c].word;
        assign flit_out[p*noc_pkg::channels+c].head  = flit_in[c].head;
        assign flit_out[p*noc_pkg::channels+c].tail  = flit_in[c].tail;
        assign port_ready[p] = route[p] && flit_out[p*noc_pkg::channels+c].ready;

        assign port_control[p].request[c]         = route[p] && flit_in[c].valid;
        assign port_control[p].free[c]            = route[p] && flit_in[c].valid && flit_in[c].ready;
        assign port_control[p].start_of_packet[c] = route[p] && start_of_packet;
        assign port_control[p].end_of_packet[c]   = route[p] && end_of_packet;
      end else begin : g_off
        assign flit_out[p*noc_pkg::channels+c].valid = 1'b0;
        assign flit_out[p*noc_pkg::channels+c].word  = '0;
        assign flit_out[p*noc_pkg::channels+c].head  = 1'b0;
        assign flit_out[p*noc_pkg::channels+c].tail  = 1'b0;
        assign port_ready[p] = 1'b0;

        assign port_control[p].request[c]         = 1'b0;
        assign port_control[p].free[c]            = 1'b0;
        assign port_control[p].start_of_packet[c] = 1'b0;
        assign port_control[p].end_of_packet[c]   = 1'b0;
      end
    end

    assign flit_in[c].ready = |port_ready;
  end

endmodule

//--- logic/router_input_path.sv
`timescale 1ns/1ns

module router_input_path #(
  parameter int                        X               = 0,
  parameter int                        Y               = 0,
  parameter logic [noc_pkg::ports-1:0] AVAILABLE_PORTS = '1
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [noc_pkg::channels-1:0]                        in_valid,
  output logic [noc_pkg::channels-1:0]                        in_ready,
  input  logic [noc_pkg::channels-1:0][noc_pkg::data_width-1:0] in_word,
  input  logic [noc_pkg::channels-1:0]                        in_head,
  input  logic [noc_pkg::channels-1:0]                        in_tail,
  output logic [noc_pkg::ports-1:0]                           out_valid,
  input  logic [noc_pkg::ports-1:0]                           out_ready,
  output logic [noc_pkg::ports-1:0][noc_pkg::data_width-1:0]  out_word,
  output logic [noc_pkg::ports-1:0]                           out_head,
  output logic [noc_pkg::ports-1:0]                           out_tail,
  output logic [noc_pkg::ports-1:0][noc_pkg::vc_width-1:0]    out_vc
);

  flit_if         link_lane [noc_pkg::channels] ();
  flit_if         fifo_lane [noc_pkg::channels] ();
  flit_if         routed [noc_pkg::ports*noc_pkg::channels] ();
  port_control_if port_ctrl [noc_pkg::ports] ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input buffering.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar c = 0; c < noc_pkg::channels; c++) begin : g_input
    assign link_lane[c].valid = in_valid[c];
    assign link_lane[c].word  = in_word[c];
    assign link_lane[c].head  = in_head[c];
    assign link_lane[c].tail  = in_tail[c];
    assign in_ready[c]        = link_lane[c].ready;

    vc_input_fifo i_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .in    (link_lane[c]),
      .out   (fifo_lane[c])
    );
  end

  route_selector #(
    .X               (X),
    .Y               (Y),
    .AVAILABLE_PORTS (AVAILABLE_PORTS)
  ) i_route_selector (
    .clk          (clk),
    .rst_n        (rst_n),
    .flit_in      (fifo_lane),
    .flit_out     (routed),
    .port_control (port_ctrl)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar p = 0; p < noc_pkg::ports; p++) begin : g_port
    if (AVAILABLE_PORTS[p]) begin : g_on
      flit_if port_lane [noc_pkg::channels] ();

      for (genvar c = 0; c < noc_pkg::channels; c++) begin : g_lane
        assign port_lane[c].valid = routed[p*noc_pkg::channels+c].valid;
        assign port_lane[c].word  = routed[p*noc_pkg::channels+c].word;
        assign port_lane[c].head  = routed[p*noc_pkg::channels+c].head;
        assign port_lane[c].tail  = routed[p*noc_pkg::channels+c].tail;
        assign routed[p*noc_pkg::channels+c].ready = port_lane[c].ready;
      end

      output_arbiter i_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .port_control (port_ctrl[p])
      );

      vc_merger i_merger (
        .clk       (clk),
        .rst_n     (rst_n),
        .grant     (port_ctrl[p].grant),
        .flit_in   (port_lane),
        .out_valid (out_valid[p]),
        .out_ready (out_ready[p]),
        .out_word  (out_word[p]),
        .out_head  (out_head[p]),
        .out_tail  (out_tail[p]),
        .out_vc    (out_vc[p])
      );
    end else begin : g_off
      for (genvar c = 0; c < noc_pkg::channels; c++) begin : g_lane
        assign routed[p*noc_pkg::channels+c].ready = 1'b0;
      end
      assign port_ctrl[p].grant = '0;
      assign out_valid[p]       = 1'b0;
      assign out_word[p]        = '0;
      assign out_head[p]        = 1'b0;
      assign out_tail[p]        = 1'b0;
      assign out_vc[p]          = '0;
    end
  end

endmodule

//--- logic/vc_input_fifo.sv
`timescale 1ns/1ns

module vc_input_fifo (
  input logic        clk,
  input logic        rst_n,
  flit_if.target     in,
  flit_if.initiator  out
);

  localparam int ptr_width   = (noc_pkg::fifo_depth > 1) ? $clog2(noc_pkg::fifo_depth) : 1;
  localparam int count_width = $clog2(noc_pkg::fifo_depth + 1);

  noc_pkg::flit_word_u         word_mem [noc_pkg::fifo_depth];
  logic [noc_pkg::fifo_depth-1:0] head_mem;
  logic [noc_pkg::fifo_depth-1:0] tail_mem;
  logic [ptr_width-1:0]        wr_ptr;
  logic [ptr_width-1:0]        rd_ptr;
  logic [count_width-1:0]      count;
  logic                        push;
  logic                        pop;

  assign in.ready  = (count != count_width'(noc_pkg::fifo_depth));
  assign out.valid = (count != '0);
  assign push      = in.valid && in.ready;
  assign pop       = out.valid && out.ready;

  // oldest entry is always offered.
  assign out.word = word_mem[rd_ptr];
  assign out.head = head_mem[rd_ptr];
  assign out.tail = tail_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      word_mem[wr_ptr] <= in.word;
      head_mem[wr_ptr] <= in.head;
      tail_mem[wr_ptr] <= in.tail;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/vc_merger.sv
`timescale 1ns/1ns

module vc_merger (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [noc_pkg::channels-1:0]    grant,
  flit_if.target                          flit_in [noc_pkg::channels],
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [noc_pkg::data_width-1:0]  out_word,
  output logic                            out_head,
  output logic                            out_tail,
  output logic [noc_pkg::vc_width-1:0]    out_vc
);

  logic [noc_pkg::channels-1:0]  lane_valid;
  logic [noc_pkg::channels-1:0]  lane_head;
  logic [noc_pkg::channels-1:0]  lane_tail;
  noc_pkg::flit_word_u           lane_word [noc_pkg::channels];
  noc_pkg::flit_word_u           sel_word;
  logic                          sel_head;
  logic                          sel_tail;
  logic [noc_pkg::vc_width-1:0]  sel_vc;
  logic                          stage_open;
  logic                          load;

  // output register can take a new flit.
  assign stage_open = !out_valid || out_ready;
  assign load       = stage_open && |(grant & lane_valid);

  for (genvar c = 0; c < noc_pkg::channels; c++) begin : g_lane
    assign lane_valid[c]    = flit_in[c].valid;
    assign lane_head[c]     = flit_in[c].head;
    assign lane_tail[c]     = flit_in[c].tail;
    assign lane_word[c]     = flit_in[c].word;
    assign flit_in[c].ready = grant[c] && stage_open;
  end

  always_comb begin
    sel_word = '0;
    sel_head = 1'b0;
    sel_tail = 1'b0;
    sel_vc   = '0;
    for (int c = 0; c < noc_pkg::channels; c++) begin
      if (grant[c]) begin
        sel_word = lane_word[c];
        sel_head = lane_head[c];
        sel_tail = lane_tail[c];
        sel_vc   = c[noc_pkg::vc_width-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (stage_open) begin
      out_valid <= |(grant & lane_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_word <= sel_word.data;
      out_head <= sel_head;
      out_tail <= sel_tail;
      out_vc   <= sel_vc;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the router input path regression with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_router_input_path \
  --Mdir obj_dir -o sim_router \
  -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_router > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

//--- test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 20;
  localparam int reset_cycles = 10;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release on a falling edge, away from the active edge.
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- test/tb_router_input_path.sv
`timescale 1ns/1ns

module tb_router_input_path;

  localparam int router_x     = 1;
  localparam int router_y     = 1;
  localparam int lanes        = noc_pkg::ports * noc_pkg::channels;
  localparam int entry_width  = noc_pkg::data_width + 2;
  localparam int ready_always = 0;
  localparam int ready_stall  = 1;
  localparam int ready_random = 2;

  logic                                                  clk;
  logic                                                  rst_n;
  logic [noc_pkg::channels-1:0]                          in_valid;
  logic [noc_pkg::channels-1:0]                          in_ready;
  logic [noc_pkg::channels-1:0][noc_pkg::data_width-1:0] in_word;
  logic [noc_pkg::channels-1:0]                          in_head;
  logic [noc_pkg::channels-1:0]                          in_tail;
  logic [noc_pkg::ports-1:0]                             out_valid;
  logic [noc_pkg::ports-1:0]                             out_ready;
  logic [noc_pkg::ports-1:0][noc_pkg::data_width-1:0]    out_word;
  logic [noc_pkg::ports-1:0]                             out_head;
  logic [noc_pkg::ports-1:0]                             out_tail;
  logic [noc_pkg::ports-1:0][noc_pkg::vc_width-1:0]      out_vc;

  // entries are {head, tail, word}, expected ones keyed by port and vc.
  logic [entry_width-1:0]       send_q [noc_pkg::channels][$];
  logic [entry_width-1:0]       expect_q [lanes][$];
  int                           ready_mode [noc_pkg::ports];
  string                        test_name;
  int                           mismatch_count;
  int                           protocol_count;
  int                           timeout_count;
  logic [noc_pkg::channels-1:0] taken;
  logic [noc_pkg::ports-1:0]    in_packet;
  logic [noc_pkg::vc_width-1:0] open_vc [noc_pkg::ports];

  clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  router_input_path #(
    .X               (router_x),
    .Y               (router_y),
    .AVAILABLE_PORTS (5'b11111)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_word   (in_word),
    .in_head   (in_head),
    .in_tail   (in_tail),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word),
    .out_head  (out_head),
    .out_tail  (out_tail),
    .out_vc    (out_vc)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // dimension-order rule seen from router (1,1).
  function automatic int expected_port(input int dx, input int dy, input logic yx_first);
    if (!yx_first) begin
      if (dx > router_x) return noc_pkg::port_x_plus;
      if (dx < router_x) return noc_pkg::port_x_minus;
    end
    if (dy > router_y) return noc_pkg::port_y_plus;
    if (dy < router_y) return noc_pkg::port_y_minus;
    if (dx > router_x) return noc_pkg::port_x_plus;
    if (dx < router_x) return noc_pkg::port_x_minus;
    return noc_pkg::port_local;
  endfunction

  function automatic bit traffic_pending();
    bit pending;
    pending = (in_valid != '0);
    for (int c = 0; c < noc_pkg::channels; c++) begin
      if (send_q[c].size() != 0) pending = 1'b1;
    end
    for (int k = 0; k < lanes; k++) begin
      if (expect_q[k].size() != 0) pending = 1'b1;
    end
    return pending;
  endfunction

  task automatic queue_packet(input int ch, input int dx, input int dy,
                              input logic yx_first, input int len);
    noc_pkg::flit_header_t          header;
    logic [noc_pkg::data_width-1:0] word;
    logic [entry_width-1:0]         entry;
    int                             key;
    key = expected_port(dx, dy, yx_first) * noc_pkg::channels + ch;
    word = $urandom;
    header.dest_x       = dx[noc_pkg::coord_width-1:0];
    header.dest_y       = dy[noc_pkg::coord_width-1:0];
    header.routing_mode = yx_first ? noc_pkg::yx_routing : noc_pkg::xy_routing;
    header.src_x        = ch[noc_pkg::coord_width-1:0];
    header.src_y        = '0;
    header.tag          = word[noc_pkg::tag_width-1:0];
    for (int i = 0; i < len; i++) begin
      if (i == 0) word = header;
      else word = $urandom;
      entry = {(i == 0), (i == len - 1), word};
      send_q[ch].push_back(entry);
      expect_q[key].push_back(entry);
    end
  endtask

  task automatic flush_traffic();
    for (int c = 0; c < noc_pkg::channels; c++) send_q[c].delete();
    for (int k = 0; k < lanes; k++) expect_q[k].delete();
  endtask

  task automatic drain_all(input int limit);
    int cycles;
    cycles = 0;
    while (traffic_pending() && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (traffic_pending()) begin
      $display("test %s: traffic still pending after %0d cycles", test_name, limit);
      timeout_count++;
      flush_traffic();
    end
  endtask

  task automatic drain_lane(input int key, input int limit);
    int cycles;
    cycles = 0;
    while (expect_q[key].size() != 0 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (expect_q[key].size() != 0) begin
      $display("test %s: lane %0d did not deliver within %0d cycles", test_name, key, limit);
      timeout_count++;
    end
  endtask

  task automatic await_reset(input int limit);
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("reset was never released within %0d cycles", limit);
      timeout_count++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // link driver and output monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    in_valid = '0;
    in_word  = '0;
    in_head  = '0;
    in_tail  = '0;
    taken    = '0;
    forever begin
      @(negedge clk);
      for (int c = 0; c < noc_pkg::channels; c++) begin
        if (taken[c] && send_q[c].size() != 0) void'(send_q[c].pop_front());
        if (send_q[c].size() != 0) begin
          {in_head[c], in_tail[c], in_word[c]} = send_q[c][0];
          in_valid[c] = 1'b1;
        end else begin
          in_valid[c] = 1'b0;
        end
        // in_ready follows the FIFO count, so it holds until the next edge.
        taken[c] = in_valid[c] && in_ready[c];
      end
    end
  end

  task automatic check_output_flit(input int p);
    logic [entry_width-1:0] expected;
    logic [entry_width-1:0] actual;
    int                     key;
    actual = {out_head[p], out_tail[p], out_word[p]};
    key = p * noc_pkg::channels + int'(out_vc[p]);
    if (in_packet[p] && out_vc[p] != open_vc[p]) begin
      $display("test %s: port %0d mixed vc %0d into the open packet of vc %0d",
               test_name, p, out_vc[p], open_vc[p]);
      protocol_count++;
    end
    if (out_head[p]) begin
      if (in_packet[p]) begin
        $display("test %s: port %0d sent a head before the previous tail", test_name, p);
        protocol_count++;
      end
      in_packet[p] = 1'b1;
      open_vc[p]   = out_vc[p];
    end else if (!in_packet[p]) begin
      $display("test %s: port %0d sent a body flit outside a packet", test_name, p);
      protocol_count++;
    end
    if (out_tail[p]) in_packet[p] = 1'b0;
    if (expect_q[key].size() == 0) begin
      $display("test %s: unexpected flit %h on port %0d vc %0d", test_name, actual, p, out_vc[p]);
      protocol_count++;
    end else begin
      expected = expect_q[key].pop_front();
      if (actual !== expected) begin
        $display("** Error [%s] port %0d vc %0d: expected %h, actual %h",
                 test_name, p, out_vc[p], expected, actual);
        mismatch_count++;
      end
    end
  endtask

  initial begin
    out_ready      = '1;
    in_packet      = '0;
    mismatch_count = 0;
    protocol_count = 0;
    for (int p = 0; p < noc_pkg::ports; p++) open_vc[p] = '0;
    forever begin
      @(negedge clk);
      for (int p = 0; p < noc_pkg::ports; p++) begin
        if (ready_mode[p] == ready_stall) out_ready[p] = 1'b0;
        else if (ready_mode[p] == ready_random) out_ready[p] = ($urandom % 4) != 0;
        else out_ready[p] = 1'b1;
        // the flit on display now leaves at the next rising edge.
        if (rst_n && out_valid[p] && out_ready[p]) check_output_flit(p);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic route_all_xy();
    test_name = "xy_routing";
    for (int dx = 0; dx < noc_pkg::size_x; dx++) begin
      for (int dy = 0; dy < noc_pkg::size_y; dy++) queue_packet((dx + dy) % 2, dx, dy, 1'b0, 1);
    end
    drain_all(2000);
  endtask

  task automatic route_all_yx();
    test_name = "yx_routing";
    for (int dx = 0; dx < noc_pkg::size_x; dx++) begin
      for (int dy = 0; dy < noc_pkg::size_y; dy++) begin
        queue_packet((dx + dy + 1) % 2, dx, dy, 1'b1, 1);
      end
    end
    drain_all(2000);
  endtask

  task automatic deliver_local();
    test_name = "local_delivery";
    queue_packet(0, router_x, router_y, 1'b0, 1);
    queue_packet(1, router_x, router_y, 1'b1, 2);
    queue_packet(0, router_x, router_y, 1'b1, 3);
    drain_all(500);
  endtask

  task automatic lock_wormhole();
    test_name = "wormhole_lock";
    queue_packet(0, 3, 2, 1'b0, 4);
    queue_packet(1, 2, 0, 1'b0, 4);
    drain_all(500);
    queue_packet(0, 1, 0, 1'b1, 4);
    queue_packet(1, 3, 0, 1'b1, 4);
    drain_all(500);
  endtask

  task automatic stall_one_port();
    int held;
    test_name = "back_pressure";
    ready_mode[noc_pkg::port_y_plus] = ready_stall;
    for (int i = 0; i < 3; i++) queue_packet(0, 1, 3, 1'b0, 3);
    for (int i = 0; i < 3; i++) queue_packet(1, 0, 1, 1'b0, 2);
    drain_lane(noc_pkg::port_x_minus * noc_pkg::channels + 1, 500);
    held = expect_q[noc_pkg::port_y_plus * noc_pkg::channels].size();
    if (held != 9) begin
      $display("** Error [%s] flits held on stalled port: expected 9, actual %0d", test_name, held);
      mismatch_count++;
    end
    @(negedge clk);
    if (in_ready[0] !== 1'b0) begin
      $display("** Error [%s] in_ready of stalled vc: expected 0, actual %b",
               test_name, in_ready[0]);
      mismatch_count++;
    end
    ready_mode[noc_pkg::port_y_plus] = ready_random;
    drain_all(2000);
    ready_mode[noc_pkg::port_y_plus] = ready_always;
  endtask

  task automatic send_random_traffic();
    test_name = "random_traffic";
    for (int p = 0; p < noc_pkg::ports; p++) ready_mode[p] = ready_random;
    for (int i = 0; i < 200; i++) begin
      queue_packet($urandom % 2, $urandom % 4, $urandom % 4, ($urandom % 2) == 1,
                   1 + $urandom % 4);
    end
    drain_all(40000);
    for (int p = 0; p < noc_pkg::ports; p++) ready_mode[p] = ready_always;
  endtask

  initial begin
    void'($urandom(32'h0f35916e));
    timeout_count = 0;
    test_name     = "reset";
    for (int p = 0; p < noc_pkg::ports; p++) ready_mode[p] = ready_always;
    await_reset(100);
    route_all_xy();
    route_all_yx();
    deliver_local();
    lock_wormhole();
    stall_one_port();
    send_random_traffic();
    $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatch_count, protocol_count, timeout_count);
    if (mismatch_count + protocol_count + timeout_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
